//--- vctrl_defines.svh
// Vector controller configuration macros
`ifndef VCTRL_DEFINES_SVH
`define VCTRL_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Register file and instruction tracking
//////////////////////////////////////////////////////////////////////

// Architectural vector registers
`define VC_NR_VREG 32
// Instructions in flight, one id each
`define VC_NR_INSN 4

// Vector register length and scalar width in bits
`define VC_VLEN 512
`define VC_ELEN 32
// Vector register length in bytes
`define VC_VLENB (`VC_VLEN / 8)

// Execution units behind the controller (VFU, LSU, SLD)
`define VC_NR_UNITS 3
// Register-file ports watched by the scoreboard
`define VC_NR_SB_PORTS 3

//////////////////////////////////////////////////////////////////////
// Vector CSR addresses
//////////////////////////////////////////////////////////////////////

`define VC_CSR_VSTART 12'h008
`define VC_CSR_VL     12'hC20
`define VC_CSR_VTYPE  12'hC21
`define VC_CSR_VLENB  12'hC22

`endif

//--- vctrl_pkg.sv
// Vector controller types
`default_nettype none

`include "vctrl_defines.svh"

package vctrl_pkg;

  // Target of a request
  typedef enum logic [1:0] {
    CON = 2'd0,
    VFU = 2'd1,
    LSU = 2'd2,
    SLD = 2'd3
  } ex_unit_e;

  // Operations retired by the controller itself
  typedef enum logic [2:0] {
    VCFG      = 3'd0,
    CSR_READ  = 3'd1,
    CSR_WRITE = 3'd2,
    CSR_SET   = 3'd3,
    CSR_CLEAR = 3'd4
  } con_op_e;

  typedef enum logic [2:0] {
    EW_8  = 3'd0,
    EW_16 = 3'd1,
    EW_32 = 3'd2
  } vsew_e;

  // Codes 4 to 7 are reserved
  typedef enum logic [2:0] {
    LMUL_1 = 3'd0,
    LMUL_2 = 3'd1,
    LMUL_4 = 3'd2,
    LMUL_8 = 3'd3
  } vlmul_e;

  typedef logic [$clog2(`VC_NR_VREG)-1:0] vreg_t;
  typedef logic [$clog2(`VC_NR_INSN)-1:0] insn_id_t;
  typedef logic [$clog2(`VC_VLEN):0]      vlen_t;
  typedef logic [`VC_ELEN-1:0]            elen_t;
  // Scalar destination register in the core
  typedef logic [4:0]                     xreg_t;

  // Same layout as the architectural vtype CSR
  typedef struct packed {
    logic                 vill;
    logic [`VC_ELEN-8:0]  reserved;
    vsew_e                vsew;
    vlmul_e               vlmul;
  } vtype_t;

  localparam vtype_t VTYPE_VILL = '{vill: 1'b1, reserved: '0, vsew: EW_8, vlmul: LMUL_1};

  typedef struct packed {
    ex_unit_e    unit;
    con_op_e     con_op;
    logic [11:0] csr_addr;
    elen_t       rs1;
    vtype_t      vtype;
    xreg_t       rd;
    vreg_t       vd;
    vreg_t       vs1;
    vreg_t       vs2;
    logic        use_vd;
    logic        use_vs1;
    logic        use_vs2;
  } vec_req_t;

  typedef struct packed {
    vec_req_t req;
    insn_id_t id;
    vlen_t    vl;
    vlen_t    vstart;
  } issued_t;

  typedef struct packed {
    xreg_t rd;
    elen_t data;
  } vfu_res_t;

endpackage

`default_nettype wire

//--- vctrl_if.sv
// Issued instruction bus
`timescale 1ns/1ps
`default_nettype none

interface issue_if
  import vctrl_pkg::*;
();

  // Vector instruction leaves the buffer towards a unit
  logic     valid;
  // Unit of the request at the buffer head
  ex_unit_e unit;
  // Instruction with its id and CSR snapshot
  issued_t  req;
  // Config or CSR instruction retires in the controller
  logic     retire_con;

  modport issuer (
    output valid,
    output unit,
    output req,
    output retire_con
  );

  modport observer (
    input valid,
    input unit,
    input req,
    input retire_con
  );

endinterface

`default_nettype wire

//--- stream_buffer.sv
// One-entry fall-through buffer
`timescale 1ns/1ps
`default_nettype none

module stream_buffer #(
  parameter type T = logic
) (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic valid_i,
  output logic      ready_o,
  input  wire T     data_i,
  output logic      valid_o,
  input  wire logic ready_i,
  output T          data_o
);

  logic full_q;
  T     data_q;

  // Empty buffer is transparent
  assign ready_o = !full_q;
  assign valid_o = full_q || valid_i;
  assign data_o  = full_q ? data_q : data_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      full_q <= !ready_i;
    end else begin
      // Hold only what the consumer did not take
      full_q <= valid_i && !ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!full_q && valid_i && !ready_i) begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- vcsr_writeback.sv
// Vector CSRs and core writeback
`timescale 1ns/1ps
`default_nettype none

`include "vctrl_defines.svh"

module vcsr_writeback
  import vctrl_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     reset_i,
  issue_if.observer     iss,
  // Scalar results of the arithmetic unit
  input  wire logic     vfu_res_valid_i,
  input  wire vfu_res_t vfu_res_i,
  output logic          vfu_res_ready_o,
  // Current CSR values
  output vlen_t         vl_o,
  output vtype_t        vtype_o,
  output vlen_t         vstart_o,
  // Results to the core
  output logic          result_valid_o,
  output xreg_t         result_rd_o,
  output elen_t         result_data_o
);

  vlen_t    vl_q, vl_d;
  vtype_t   vtype_q, vtype_d;
  vlen_t    vstart_q, vstart_d;
  vec_req_t req;
  vlen_t    vlmax;
  logic     vtype_legal;
  elen_t    csr_rdata;
  vfu_res_t vfu_res;
  logic     vfu_valid;
  logic     vfu_pop;

  assign req = iss.req.req;

  //////////////////////////////////////////////////////////////////////
  // CSR registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vl_q     <= '0;
      vtype_q  <= VTYPE_VILL;
      vstart_q <= '0;
    end else begin
      vl_q     <= vl_d;
      vtype_q  <= vtype_d;
      vstart_q <= vstart_d;
    end
  end

  // Up to 32 bit elements, integer LMUL only
  assign vtype_legal = (req.vtype.vsew inside {EW_8, EW_16, EW_32}) &&
                       (req.vtype.vlmul inside {LMUL_1, LMUL_2, LMUL_4, LMUL_8});

  // Elements per register scaled by LMUL
  assign vlmax = (vlen_t'(`VC_VLENB) >> req.vtype.vsew) << req.vtype.vlmul;

  always_comb begin
    vl_d     = vl_q;
    vtype_d  = vtype_q;
    vstart_d = vstart_q;

    // Vector work restarts from element 0 next time
    if (iss.valid && iss.unit != CON) begin
      vstart_d = '0;
    end

    if (iss.retire_con) begin
      case (req.con_op)
        VCFG: begin
          if (vtype_legal) begin
            vtype_d = '{vill: 1'b0, reserved: '0, vsew: req.vtype.vsew, vlmul: req.vtype.vlmul};
            if (req.rs1 == '1) begin
              vl_d = vlmax;
            end else if (req.rs1 < elen_t'(vlmax)) begin
              vl_d = vlen_t'(req.rs1);
            end else begin
              vl_d = vlmax;
            end
          end else begin
            vtype_d = VTYPE_VILL;
            vl_d    = '0;
          end
        end
        // Only vstart is writable
        CSR_WRITE: begin
          if (req.csr_addr == `VC_CSR_VSTART) vstart_d = vlen_t'(req.rs1);
        end
        CSR_SET: begin
          if (req.csr_addr == `VC_CSR_VSTART) vstart_d = vstart_q | vlen_t'(req.rs1);
        end
        CSR_CLEAR: begin
          if (req.csr_addr == `VC_CSR_VSTART) vstart_d = vstart_q & ~vlen_t'(req.rs1);
        end
        default: begin
        end
      endcase
    end
  end

  assign vl_o     = vl_q;
  assign vtype_o  = vtype_q;
  assign vstart_o = vstart_q;

  //////////////////////////////////////////////////////////////////////
  // Writeback
  //////////////////////////////////////////////////////////////////////

  // Old value of the addressed CSR
  always_comb begin
    case (req.csr_addr)
      `VC_CSR_VSTART: csr_rdata = elen_t'(vstart_q);
      `VC_CSR_VL:     csr_rdata = elen_t'(vl_q);
      `VC_CSR_VTYPE:  csr_rdata = elen_t'(vtype_q);
      `VC_CSR_VLENB:  csr_rdata = elen_t'(`VC_VLENB);
      default:        csr_rdata = '0;
    endcase
  end

  stream_buffer #(
    .T(vfu_res_t)
  ) u_vfu_res_buf (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (vfu_res_valid_i),
    .ready_o (vfu_res_ready_o),
    .data_i  (vfu_res_i),
    .valid_o (vfu_valid),
    .ready_i (vfu_pop),
    .data_o  (vfu_res)
  );

  // Controller retire wins over the arithmetic unit
  always_comb begin
    result_valid_o = 1'b0;
    result_rd_o    = '0;
    result_data_o  = '0;
    vfu_pop        = 1'b0;
    if (iss.retire_con) begin
      result_valid_o = 1'b1;
      result_rd_o    = req.rd;
      result_data_o  = (req.con_op == VCFG) ? elen_t'(vl_d) : csr_rdata;
    end else if (vfu_valid) begin
      result_valid_o = 1'b1;
      result_rd_o    = vfu_res.rd;
      result_data_o  = vfu_res.data;
      vfu_pop        = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- issue_ctrl.sv
// Request buffer and instruction issue
`timescale 1ns/1ps
`default_nettype none

`include "vctrl_defines.svh"

module issue_ctrl
  import vctrl_pkg::*;
(
  input  wire logic                        clk_i,
  input  wire logic                        reset_i,
  input  wire logic                        req_valid_i,
  input  wire vec_req_t                    req_i,
  output logic                             req_ready_o,
  output logic                             req_accept_o,
  input  wire logic [`VC_NR_UNITS-1:0]     unit_ready_i,
  input  wire logic [`VC_NR_UNITS-1:0]     done_valid_i,
  input  wire insn_id_t [`VC_NR_UNITS-1:0] done_id_i,
  input  wire vlen_t                       vl_i,
  input  wire vtype_t                      vtype_i,
  input  wire vlen_t                       vstart_i,
  issue_if.issuer                          iss,
  output logic                             busy_o
);

  vec_req_t               head;
  logic                   head_valid;
  logic                   pop;
  logic                   unit_ok;
  logic                   ids_full;
  logic                   vec_issue;
  insn_id_t               free_id;
  issued_t                issued;
  logic [`VC_NR_INSN-1:0] running_q, running_d;

  // Vector requests need a legal vtype
  assign req_accept_o = req_valid_i && req_ready_o && !((req_i.unit != CON) && vtype_i.vill);

  stream_buffer #(
    .T(vec_req_t)
  ) u_req_buf (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (req_accept_o),
    .ready_o (req_ready_o),
    .data_i  (req_i),
    .valid_o (head_valid),
    .ready_i (pop),
    .data_o  (head)
  );

  always_comb begin
    case (head.unit)
      VFU:     unit_ok = unit_ready_i[0];
      LSU:     unit_ok = unit_ready_i[1];
      SLD:     unit_ok = unit_ready_i[2];
      default: unit_ok = 1'b1;
    endcase
  end

  // Lowest free id
  always_comb begin
    free_id = '0;
    for (int i = `VC_NR_INSN - 1; i >= 0; i--) begin
      if (!running_q[i]) free_id = insn_id_t'(i);
    end
  end

  assign ids_full  = &running_q;
  assign pop       = head_valid && unit_ok && ((head.unit == CON) || !ids_full);
  assign vec_issue = pop && (head.unit != CON);

  always_comb begin
    running_d = running_q;
    if (vec_issue) running_d[free_id] = 1'b1;
    for (int u = 0; u < `VC_NR_UNITS; u++) begin
      if (done_valid_i[u]) running_d[done_id_i[u]] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

  // Snapshot of the CSRs before this cycle's update
  always_comb begin
    issued        = '0;
    issued.req    = head;
    issued.id     = free_id;
    issued.vl     = vl_i;
    issued.vstart = vstart_i;
    // CON keeps its requested vtype for VCFG
    if (head.unit != CON) issued.req.vtype = vtype_i;
  end

  assign iss.valid      = vec_issue;
  assign iss.unit       = head.unit;
  assign iss.req        = issued;
  assign iss.retire_con = pop && (head.unit == CON);

  assign busy_o = |running_q;

endmodule

`default_nettype wire

//--- vreg_scoreboard.sv
// Vector register hazard scoreboard
`timescale 1ns/1ps
`default_nettype none

`include "vctrl_defines.svh"

module vreg_scoreboard
  import vctrl_pkg::*;
(
  input  wire logic                           clk_i,
  input  wire logic                           reset_i,
  issue_if.observer                           iss,
  input  wire logic [`VC_NR_UNITS-1:0]        done_valid_i,
  input  wire insn_id_t [`VC_NR_UNITS-1:0]    done_id_i,
  input  wire logic [`VC_NR_SB_PORTS-1:0]     sb_req_i,
  input  wire insn_id_t [`VC_NR_SB_PORTS-1:0] sb_id_i,
  output logic [`VC_NR_SB_PORTS-1:0]          sb_grant_o
);

  // Last reader or writer of a register
  typedef struct packed {
    insn_id_t id;
    logic     valid;
  } sb_entry_t;

  sb_entry_t [`VC_NR_VREG-1:0]            rd_tab_q, rd_tab_d;
  sb_entry_t [`VC_NR_VREG-1:0]            wr_tab_q, wr_tab_d;
  // Row i holds the ids instruction i waits for
  logic [`VC_NR_INSN-1:0][`VC_NR_INSN-1:0] deps_q, deps_d;
  logic [`VC_NR_INSN-1:0]                 done_mask;
  logic [`VC_NR_INSN-1:0]                 new_deps;
  issued_t                                insn;

  assign insn = iss.req;

  always_comb begin
    done_mask = '0;
    for (int u = 0; u < `VC_NR_UNITS; u++) begin
      if (done_valid_i[u]) done_mask[done_id_i[u]] = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Table and dependency update
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_tab_d = rd_tab_q;
    wr_tab_d = wr_tab_q;
    deps_d   = deps_q;
    new_deps = '0;

    // Completed ids release their registers
    for (int v = 0; v < `VC_NR_VREG; v++) begin
      if (rd_tab_q[v].valid && done_mask[rd_tab_q[v].id]) rd_tab_d[v] = '0;
      if (wr_tab_q[v].valid && done_mask[wr_tab_q[v].id]) wr_tab_d[v] = '0;
    end
    for (int i = 0; i < `VC_NR_INSN; i++) begin
      if (done_mask[i]) deps_d[i] = '0;
      deps_d[i] = deps_d[i] & ~done_mask;
    end

    if (iss.valid) begin
      // RAW
      if (insn.req.use_vs1 && wr_tab_d[insn.req.vs1].valid) begin
        new_deps[wr_tab_d[insn.req.vs1].id] = 1'b1;
      end
      if (insn.req.use_vs2 && wr_tab_d[insn.req.vs2].valid) begin
        new_deps[wr_tab_d[insn.req.vs2].id] = 1'b1;
      end
      // WAW and WAR
      if (insn.req.use_vd) begin
        if (wr_tab_d[insn.req.vd].valid) new_deps[wr_tab_d[insn.req.vd].id] = 1'b1;
        if (rd_tab_d[insn.req.vd].valid) new_deps[rd_tab_d[insn.req.vd].id] = 1'b1;
      end
      new_deps[insn.id] = 1'b0;
      deps_d[insn.id]   = new_deps;

      // Claim the registers
      if (insn.req.use_vs1) rd_tab_d[insn.req.vs1] = '{id: insn.id, valid: 1'b1};
      if (insn.req.use_vs2) rd_tab_d[insn.req.vs2] = '{id: insn.id, valid: 1'b1};
      if (insn.req.use_vd)  wr_tab_d[insn.req.vd]  = '{id: insn.id, valid: 1'b1};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_tab_q <= '0;
      wr_tab_q <= '0;
      deps_q   <= '0;
    end else begin
      rd_tab_q <= rd_tab_d;
      wr_tab_q <= wr_tab_d;
      deps_q   <= deps_d;
    end
  end

  // Completions of this cycle already release a port
  always_comb begin
    for (int p = 0; p < `VC_NR_SB_PORTS; p++) begin
      sb_grant_o[p] = sb_req_i[p] && ((deps_q[sb_id_i[p]] & ~done_mask) == '0);
    end
  end

endmodule

`default_nettype wire

//--- vector_controller.sv
// Vector coprocessor controller
`timescale 1ns/1ps
`default_nettype none

`include "vctrl_defines.svh"

module vector_controller
  import vctrl_pkg::*;
(
  input  wire logic                           clk_i,
  input  wire logic                           reset_i,
  // Requests from the core
  input  wire logic                           req_valid_i,
  input  wire vec_req_t                       req_i,
  output logic                                req_ready_o,
  output logic                                req_accept_o,
  // Execution units
  input  wire logic [`VC_NR_UNITS-1:0]        unit_ready_i,
  output logic                                issue_valid_o,
  output issued_t                             issue_o,
  input  wire logic [`VC_NR_UNITS-1:0]        done_valid_i,
  input  wire insn_id_t [`VC_NR_UNITS-1:0]    done_id_i,
  // Register-file ports
  input  wire logic [`VC_NR_SB_PORTS-1:0]     sb_req_i,
  input  wire insn_id_t [`VC_NR_SB_PORTS-1:0] sb_id_i,
  output logic [`VC_NR_SB_PORTS-1:0]          sb_grant_o,
  // Arithmetic-unit scalar results
  input  wire logic                           vfu_res_valid_i,
  input  wire vfu_res_t                       vfu_res_i,
  output logic                                vfu_res_ready_o,
  // Results to the core
  output logic                                result_valid_o,
  output xreg_t                               result_rd_o,
  output elen_t                               result_data_o,
  output logic                                busy_o
);

  vlen_t  vl_q;
  vtype_t vtype_q;
  vlen_t  vstart_q;

  issue_if issue_bus ();

  issue_ctrl u_issue_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .req_accept_o (req_accept_o),
    .unit_ready_i (unit_ready_i),
    .done_valid_i (done_valid_i),
    .done_id_i    (done_id_i),
    .vl_i         (vl_q),
    .vtype_i      (vtype_q),
    .vstart_i     (vstart_q),
    .iss          (issue_bus.issuer),
    .busy_o       (busy_o)
  );

  vcsr_writeback u_vcsr_writeback (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .iss             (issue_bus.observer),
    .vfu_res_valid_i (vfu_res_valid_i),
    .vfu_res_i       (vfu_res_i),
    .vfu_res_ready_o (vfu_res_ready_o),
    .vl_o            (vl_q),
    .vtype_o         (vtype_q),
    .vstart_o        (vstart_q),
    .result_valid_o  (result_valid_o),
    .result_rd_o     (result_rd_o),
    .result_data_o   (result_data_o)
  );

  vreg_scoreboard u_vreg_scoreboard (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .iss          (issue_bus.observer),
    .done_valid_i (done_valid_i),
    .done_id_i    (done_id_i),
    .sb_req_i     (sb_req_i),
    .sb_id_i      (sb_id_i),
    .sb_grant_o   (sb_grant_o)
  );

  assign issue_valid_o = issue_bus.valid;
  assign issue_o       = issue_bus.req;

endmodule

`default_nettype wire

//--- tb_vector_controller.sv
// Vector controller testbench
`timescale 1ns/1ps
`default_nettype none

`include "vctrl_defines.svh"

module tb_vector_controller
  import vctrl_pkg::*;
();

  localparam int CLK_HALF   = 20;
  localparam int DRIVE_SKEW = 2;
  localparam int MAX_CYCLES = 2000;

  logic                                clk_i;
  logic                                reset_i;
  logic                                req_valid_i;
  vec_req_t                            req_i;
  logic                                req_ready_o;
  logic                                req_accept_o;
  logic [`VC_NR_UNITS-1:0]             unit_ready_i;
  logic                                issue_valid_o;
  issued_t                             issue_o;
  logic [`VC_NR_UNITS-1:0]             done_valid_i;
  insn_id_t [`VC_NR_UNITS-1:0]         done_id_i;
  logic [`VC_NR_SB_PORTS-1:0]          sb_req_i;
  insn_id_t [`VC_NR_SB_PORTS-1:0]      sb_id_i;
  logic [`VC_NR_SB_PORTS-1:0]          sb_grant_o;
  logic                                vfu_res_valid_i;
  vfu_res_t                            vfu_res_i;
  logic                                vfu_res_ready_o;
  logic                                result_valid_o;
  xreg_t                               result_rd_o;
  elen_t                               result_data_o;
  logic                                busy_o;

  int          errors;
  int          checks;
  int          cycles;
  logic [31:0] lfsr_q;
  vreg_t       regs [8];

  // Expected CSR state from the architectural rules
  elen_t       exp_vl;
  vtype_t      exp_vtype;
  elen_t       exp_vstart;

  vector_controller DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_elen(input string name, input elen_t got, input elen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input insn_id_t got, input insn_id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_vtype(input string name, input vtype_t got, input vtype_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers and reference rules
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit
  function automatic vreg_t random_vreg();
    vreg_t v;
    v = '0;
    for (int i = 0; i < $bits(vreg_t); i++) begin
      v = {v[$bits(vreg_t)-2:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  task automatic pick_distinct_regs();
    logic [`VC_NR_VREG-1:0] used;
    used = '0;
    for (int k = 0; k < 8; k++) begin
      regs[k] = random_vreg();
      while (used[regs[k]]) begin
        regs[k] = random_vreg();
      end
      used[regs[k]] = 1'b1;
    end
  endtask

  function automatic vtype_t make_vtype(input logic [2:0] sew, input logic [2:0] lmul);
    vtype_t v;
    v       = '0;
    v.vsew  = vsew_e'(sew);
    v.vlmul = vlmul_e'(lmul);
    return v;
  endfunction

  function automatic vtype_t vill_vtype();
    vtype_t v;
    v      = '0;
    v.vill = 1'b1;
    return v;
  endfunction

  // Vl of 0 for wider elements or a reserved LMUL
  function automatic elen_t expected_vl(input logic [2:0] sew, input logic [2:0] lmul,
                                        input elen_t rs1);
    elen_t vlmax;
    if (sew > 3'd2 || lmul > 3'd3) return '0;
    vlmax = (`VC_VLEN / 8 / (1 << sew)) * (1 << lmul);
    if (rs1 == '1) return vlmax;
    return (rs1 < vlmax) ? rs1 : vlmax;
  endfunction

  function automatic vec_req_t make_con(input con_op_e op, input logic [11:0] addr,
                                        input elen_t rs1, input vtype_t vt, input xreg_t rd);
    vec_req_t r;
    r          = '0;
    r.unit     = CON;
    r.con_op   = op;
    r.csr_addr = addr;
    r.rs1      = rs1;
    r.vtype    = vt;
    r.rd       = rd;
    return r;
  endfunction

  function automatic vec_req_t make_vec(input ex_unit_e unit, input vreg_t vd, input vreg_t vs1,
                                        input vreg_t vs2, input logic [2:0] uses);
    vec_req_t r;
    r         = '0;
    r.unit    = unit;
    r.vd      = vd;
    r.vs1     = vs1;
    r.vs2     = vs2;
    r.use_vd  = uses[2];
    r.use_vs1 = uses[1];
    r.use_vs2 = uses[0];
    return r;
  endfunction

  task automatic step();
    @(posedge clk_i);
    #DRIVE_SKEW;
  endtask

  // Holds the request until the handshake and samples outputs mid-cycle
  task automatic send_req(input vec_req_t r, output logic acc, output logic res_v,
                          output xreg_t res_rd, output elen_t res_d,
                          output logic iss_v, output issued_t iss);
    step();
    req_valid_i = 1'b1;
    req_i       = r;
    @(negedge clk_i);
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    acc    = req_accept_o;
    res_v  = result_valid_o;
    res_rd = result_rd_o;
    res_d  = result_data_o;
    iss_v  = issue_valid_o;
    iss    = issue_o;
    step();
    req_valid_i = 1'b0;
    req_i       = '0;
  endtask

  task automatic run_con(input con_op_e op, input logic [11:0] addr, input elen_t rs1,
                         input vtype_t vt, output elen_t data);
    logic    acc;
    logic    res_v;
    logic    iss_v;
    xreg_t   rd;
    xreg_t   res_rd;
    issued_t iss;
    rd = xreg_t'(random_vreg());
    send_req(make_con(op, addr, rs1, vt, rd), acc, res_v, res_rd, data, iss_v, iss);
    check_bit("req_accept_o", acc, 1'b1);
    check_bit("result_valid_o", res_v, 1'b1);
    check_elen("result_rd_o", elen_t'(res_rd), elen_t'(rd));
    check_bit("issue_valid_o", iss_v, 1'b0);
  endtask

  task automatic issue_vec(input ex_unit_e unit, input vreg_t vd, input vreg_t vs1,
                           input vreg_t vs2, input logic exp_iss, input insn_id_t exp_id);
    logic    acc;
    logic    res_v;
    logic    iss_v;
    xreg_t   res_rd;
    elen_t   res_d;
    issued_t iss;
    send_req(make_vec(unit, vd, vs1, vs2, 3'b111), acc, res_v, res_rd, res_d, iss_v, iss);
    check_bit("req_accept_o", acc, 1'b1);
    check_bit("issue_valid_o", iss_v, exp_iss);
    if (exp_iss) begin
      check_id("issue_o.id", iss.id, exp_id);
      check_elen("issue_o.req.unit", elen_t'(iss.req.unit), elen_t'(unit));
      check_elen("issue_o.req.vd", elen_t'(iss.req.vd), elen_t'(vd));
      check_elen("issue_o.vl", elen_t'(iss.vl), exp_vl);
      check_vtype("issue_o.req.vtype", iss.req.vtype, exp_vtype);
      check_elen("issue_o.vstart", elen_t'(iss.vstart), exp_vstart);
      exp_vstart = '0;
    end
  endtask

  task automatic wait_issue(input insn_id_t exp_id);
    @(negedge clk_i);
    while (!issue_valid_o) begin
      @(negedge clk_i);
    end
    check_id("issue_o.id", issue_o.id, exp_id);
  endtask

  task automatic finish_id(input int unit, input insn_id_t id);
    step();
    done_valid_i[unit] = 1'b1;
    done_id_i[unit]    = id;
    step();
    done_valid_i = '0;
  endtask

  task automatic check_vcfg(input logic [2:0] sew, input logic [2:0] lmul, input elen_t rs1);
    elen_t data;
    run_con(VCFG, 12'h000, rs1, make_vtype(sew, lmul), data);
    exp_vl = expected_vl(sew, lmul, rs1);
    check_elen("VCFG result", data, exp_vl);
    exp_vtype = (sew > 3'd2 || lmul > 3'd3) ? vill_vtype() : make_vtype(sew, lmul);
    run_con(CSR_READ, `VC_CSR_VTYPE, '0, '0, data);
    check_vtype("vtype readback", vtype_t'(data), exp_vtype);
  endtask

  // Old value comes back and the new value follows the CSR operation
  task automatic csr_step(input con_op_e op, input elen_t rs1);
    elen_t data;
    run_con(op, `VC_CSR_VSTART, rs1, '0, data);
    check_elen("vstart old value", data, exp_vstart);
    case (op)
      CSR_WRITE: exp_vstart = rs1;
      CSR_SET:   exp_vstart = exp_vstart | rs1;
      CSR_CLEAR: exp_vstart = exp_vstart & ~rs1;
      default:   exp_vstart = exp_vstart;
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_vcfg();
    elen_t data;
    run_con(CSR_READ, `VC_CSR_VTYPE, '0, '0, data);
    check_vtype("vtype after reset", vtype_t'(data), vill_vtype());
    run_con(CSR_READ, `VC_CSR_VL, '0, '0, data);
    check_elen("vl after reset", data, '0);
    check_vcfg(3'd2, 3'd0, '1);
    check_vcfg(3'd0, 3'd3, 32'd100);
    check_vcfg(3'd1, 3'd1, 32'd40);
    check_vcfg(3'd2, 3'd2, 32'd1000);
    check_vcfg(3'd0, 3'd0, '1);
    // 64 bit elements and a reserved LMUL
    check_vcfg(3'd3, 3'd0, 32'd8);
    check_vcfg(3'd1, 3'd5, 32'd8);
  endtask

  task automatic test_csr_ops();
    elen_t data;
    check_vcfg(3'd2, 3'd0, '1);
    csr_step(CSR_WRITE, 32'h05);
    csr_step(CSR_SET, 32'h18);
    csr_step(CSR_CLEAR, 32'h01);
    csr_step(CSR_READ, '0);
    run_con(CSR_READ, `VC_CSR_VLENB, '0, '0, data);
    check_elen("vlenb", data, 32'd64);
    run_con(CSR_READ, `VC_CSR_VL, '0, '0, data);
    check_elen("vl readback", data, exp_vl);
  endtask

  task automatic test_issue();
    logic    acc;
    logic    res_v;
    logic    iss_v;
    xreg_t   res_rd;
    elen_t   data;
    issued_t iss;
    pick_distinct_regs();
    issue_vec(VFU, regs[0], regs[1], regs[2], 1'b1, 2'd0);
    run_con(CSR_READ, `VC_CSR_VSTART, '0, '0, data);
    check_elen("vstart after issue", data, '0);
    issue_vec(LSU, regs[3], regs[4], regs[5], 1'b1, 2'd1);
    finish_id(0, 2'd0);
    issue_vec(SLD, regs[6], regs[7], regs[6], 1'b1, 2'd0);
    finish_id(1, 2'd1);
    finish_id(2, 2'd0);
    // Illegal vtype blocks vector work
    check_vcfg(3'd3, 3'd0, 32'd8);
    send_req(make_vec(VFU, regs[0], regs[1], regs[2], 3'b111), acc, res_v, res_rd, data,
             iss_v, iss);
    check_bit("req_accept_o", acc, 1'b0);
    check_bit("issue_valid_o", iss_v, 1'b0);
    @(negedge clk_i);
    check_bit("issue_valid_o", issue_valid_o, 1'b0);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    check_vcfg(3'd2, 3'd1, 32'd20);
  endtask

  task automatic test_backpressure();
    pick_distinct_regs();
    step();
    unit_ready_i = '0;
    issue_vec(VFU, regs[0], regs[1], regs[2], 1'b0, 2'd0);
    @(negedge clk_i);
    check_bit("req_ready_o", req_ready_o, 1'b0);
    check_bit("issue_valid_o", issue_valid_o, 1'b0);
    step();
    unit_ready_i = '1;
    wait_issue(2'd0);
    issue_vec(LSU, regs[3], regs[4], regs[5], 1'b1, 2'd1);
    issue_vec(SLD, regs[6], regs[7], regs[6], 1'b1, 2'd2);
    issue_vec(VFU, regs[1], regs[2], regs[3], 1'b1, 2'd3);
    // All four ids in use
    issue_vec(LSU, regs[4], regs[5], regs[7], 1'b0, 2'd0);
    @(negedge clk_i);
    check_bit("req_ready_o", req_ready_o, 1'b0);
    check_bit("issue_valid_o", issue_valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b1);
    finish_id(1, 2'd2);
    wait_issue(2'd2);
    finish_id(0, 2'd0);
    finish_id(1, 2'd1);
    finish_id(2, 2'd2);
    finish_id(0, 2'd3);
    @(negedge clk_i);
    check_bit("busy_o", busy_o, 1'b0);
  endtask

  task automatic test_scoreboard();
    pick_distinct_regs();
    issue_vec(VFU, regs[0], regs[1], regs[2], 1'b1, 2'd0);
    // Second one reads the first one's vd
    issue_vec(LSU, regs[3], regs[0], regs[4], 1'b1, 2'd1);
    issue_vec(SLD, regs[5], regs[6], regs[7], 1'b1, 2'd2);
    step();
    sb_req_i   = '1;
    sb_id_i[0] = 2'd1;
    sb_id_i[1] = 2'd2;
    sb_id_i[2] = 2'd0;
    @(negedge clk_i);
    check_bit("sb_grant_o[0]", sb_grant_o[0], 1'b0);
    check_bit("sb_grant_o[1]", sb_grant_o[1], 1'b1);
    check_bit("sb_grant_o[2]", sb_grant_o[2], 1'b1);
    step();
    done_valid_i[0] = 1'b1;
    done_id_i[0]    = 2'd0;
    @(negedge clk_i);
    check_bit("sb_grant_o[0]", sb_grant_o[0], 1'b1);
    step();
    done_valid_i = '0;
    @(negedge clk_i);
    check_bit("sb_grant_o[0]", sb_grant_o[0], 1'b1);
    step();
    sb_req_i = '0;
    finish_id(1, 2'd1);
    finish_id(2, 2'd2);
  endtask

  task automatic test_results();
    step();
    vfu_res_valid_i = 1'b1;
    vfu_res_i       = '{rd: 5'd3, data: 32'hcafe_0123};
    @(negedge clk_i);
    check_bit("vfu_res_ready_o", vfu_res_ready_o, 1'b1);
    check_bit("result_valid_o", result_valid_o, 1'b1);
    check_elen("result_rd_o", elen_t'(result_rd_o), 32'd3);
    check_elen("result_data_o", result_data_o, 32'hcafe_0123);
    // Collision with a CSR read of vl
    step();
    vfu_res_i   = '{rd: 5'd4, data: 32'h1357_9bdf};
    req_valid_i = 1'b1;
    req_i       = make_con(CSR_READ, `VC_CSR_VL, '0, '0, 5'd12);
    @(negedge clk_i);
    check_bit("req_accept_o", req_accept_o, 1'b1);
    check_bit("result_valid_o", result_valid_o, 1'b1);
    check_elen("result_rd_o", elen_t'(result_rd_o), 32'd12);
    check_elen("result_data_o", result_data_o, exp_vl);
    step();
    req_valid_i     = 1'b0;
    req_i           = '0;
    vfu_res_valid_i = 1'b0;
    @(negedge clk_i);
    check_bit("result_valid_o", result_valid_o, 1'b1);
    check_elen("result_rd_o", elen_t'(result_rd_o), 32'd4);
    check_elen("result_data_o", result_data_o, 32'h1357_9bdf);
    step();
    @(negedge clk_i);
    check_bit("result_valid_o", result_valid_o, 1'b0);
    issue_vec(VFU, regs[0], regs[1], regs[2], 1'b1, 2'd0);
    @(negedge clk_i);
    check_bit("busy_o", busy_o, 1'b1);
    finish_id(0, 2'd0);
    @(negedge clk_i);
    check_bit("busy_o", busy_o, 1'b0);
  endtask

  initial begin
    errors          = 0;
    checks          = 0;
    lfsr_q          = 32'h9156dc26;
    exp_vl          = '0;
    exp_vtype       = vill_vtype();
    exp_vstart      = '0;
    reset_i         = 1'b1;
    req_valid_i     = 1'b0;
    req_i           = '0;
    unit_ready_i    = '1;
    done_valid_i    = '0;
    done_id_i       = '0;
    sb_req_i        = '0;
    sb_id_i         = '0;
    vfu_res_valid_i = 1'b0;
    vfu_res_i       = '0;
    repeat (5) @(posedge clk_i);
    #DRIVE_SKEW;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_bit("req_accept_o", req_accept_o, 1'b0);
    check_bit("issue_valid_o", issue_valid_o, 1'b0);
    check_bit("result_valid_o", result_valid_o, 1'b0);
    check_bit("sb_grant_o", |sb_grant_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);

    test_vcfg();
    test_csr_ops();
    test_issue();
    test_backpressure();
    test_scoreboard();
    test_results();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
vctrl_pkg.sv
vctrl_if.sv
stream_buffer.sv
vcsr_writeback.sv
issue_ctrl.sv
vreg_scoreboard.sv
vector_controller.sv
tb_vector_controller.sv
